/* logic/mesh_router_cfg.svh */
// ------------------------------------------------
// Build-time sizes for the mesh router
// Included by the packet package and the input FIFO
// ------------------------------------------------
`ifndef MESH_ROUTER_CFG_SVH
`define MESH_ROUTER_CFG_SVH

// Mesh dimensions in nodes
`define MESH_X_NODES 4
`define MESH_Y_NODES 4

// Bits per coordinate, enough for the larger mesh axis
`define MESH_COORD_W 2

// Packet payload bits
`define MESH_PAYLOAD_W 16

// Packets held per input FIFO
`define MESH_FIFO_DEPTH 4

`endif

/* logic/mesh_pkt_pkg.sv */
// ------------------------------------------------
// Packet format carried on every router link
// Single-flit packet with XY destination and payload
// ------------------------------------------------
`include "mesh_router_cfg.svh"

package mesh_pkt_pkg;

  // Coordinate along one mesh axis
  typedef logic [`MESH_COORD_W-1:0] coord_t;

  // Payload word
  typedef logic [`MESH_PAYLOAD_W-1:0] payload_t;

  // ------------------------------------------------
  // Packet layout, destination X in the top bits
  // ------------------------------------------------
  // X and Y are kept apart so a mesh of any size can be addressed
  // without splitting one node number in half
  typedef struct packed {
    coord_t   dest_x;  // Destination column
    coord_t   dest_y;  // Destination row
    payload_t payload; // User data, passed through untouched
  } packet_t;

  // Width of a packet on the wire
  localparam int PKT_W = $bits(packet_t);

endpackage

/* logic/mesh_port_pkg.sv */
// ------------------------------------------------
// Router port naming and per-port request words
// ------------------------------------------------

package mesh_port_pkg;

  // Five ports on a 2D mesh router
  localparam int NUM_PORTS = 5;

  // Port index, same order on inputs and outputs
  typedef enum logic [2:0] {
    PORT_CORE  = 3'd0, // Local core
    PORT_NORTH = 3'd1, // Towards higher Y
    PORT_EAST  = 3'd2, // Towards higher X
    PORT_SOUTH = 3'd3, // Towards lower Y
    PORT_WEST  = 3'd4  // Towards lower X
  } port_e;

  // One bit per port
  // Per input it holds the requested output
  // Per output it holds the granted input
  typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage

/* logic/mesh_input_fifo.sv */
// ------------------------------------------------
// First-word-fall-through packet FIFO on one router input
// Head and head valid feed the route calculator, i_pop drains
// ------------------------------------------------
`timescale 1ns/1ps
`include "mesh_router_cfg.svh"

module mesh_input_fifo (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  mesh_pkt_pkg::packet_t i_data,     // Packet from upstream link
  input  logic                  i_data_val, // Upstream strobe
  output logic                  o_en,       // Space left, upstream may send
  input  logic                  i_pop,      // Head granted, drop it at the edge
  output mesh_pkt_pkg::packet_t o_data,     // Head packet
  output logic                  o_data_val  // Head is valid
);

  import mesh_pkt_pkg::*;

  localparam int DEPTH = `MESH_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  packet_t          mem [DEPTH]; // Packet storage, no reset needed
  logic [PTR_W-1:0] wr_ptr;      // Next slot to fill
  logic [PTR_W-1:0] rd_ptr;      // Current head slot
  logic [CNT_W-1:0] count;       // Packets held
  logic             push;
  logic             pop;

  // Wrap a pointer at DEPTH, works for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ------------------------------------------------
  // Flags and head
  // ------------------------------------------------
  assign o_en       = (count != CNT_W'(DEPTH)); // Low only when full
  assign o_data_val = (count != '0);
  assign o_data     = mem[rd_ptr];               // Falls through, no read latency

  assign push = i_data_val & o_en; // Offer while full is lost
  assign pop  = i_pop & o_data_val;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Idle or push with pop
      endcase
    end
  end

  // Switch control only grants heads that are present
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_pop |-> o_data_val)
    else $error("pop of an empty input FIFO");

  // When full the write slot is the head slot, so a stray write would overwrite it
  a_no_write_full: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_data_val && !o_en && !i_pop) |=> $stable(o_data))
    else $error("write accepted while input FIFO full");

endmodule

/* logic/mesh_route_calc.sv */
// ------------------------------------------------
// XY route calculation on one FIFO head
// Gives a one-hot output request, zero when no head
// ------------------------------------------------
`timescale 1ns/1ps

module mesh_route_calc #(
  parameter int unsigned X_LOC = 0, // Router column
  parameter int unsigned Y_LOC = 0  // Router row
) (
  input  mesh_pkt_pkg::packet_t    i_pkt,       // Head packet
  input  logic                     i_val,       // Head valid
  output mesh_port_pkg::port_vec_t o_output_req // One-hot requested output
);

  import mesh_pkt_pkg::*;
  import mesh_port_pkg::*;

  localparam coord_t HERE_X = coord_t'(X_LOC);
  localparam coord_t HERE_Y = coord_t'(Y_LOC);

  port_e dir; // Chosen output port

  // ------------------------------------------------
  // Dimension order, X is resolved before Y
  // ------------------------------------------------
  always_comb begin
    if (i_pkt.dest_x > HERE_X) begin
      dir = PORT_EAST;
    end else if (i_pkt.dest_x < HERE_X) begin
      dir = PORT_WEST;
    end else if (i_pkt.dest_y > HERE_Y) begin
      dir = PORT_NORTH;
    end else if (i_pkt.dest_y < HERE_Y) begin
      dir = PORT_SOUTH;
    end else begin
      dir = PORT_CORE; // Arrived, hand to local core
    end
  end

  always_comb begin
    o_output_req = '0;
    if (i_val) begin
      o_output_req[dir] = 1'b1;
    end
  end

endmodule

/* logic/mesh_switch_control.sv */
// ------------------------------------------------
// Switch control, one round-robin arbiter per output
// Grants are per output, pops are per input
// ------------------------------------------------
`timescale 1ns/1ps

module mesh_switch_control (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_en           [mesh_port_pkg::NUM_PORTS], // Downstream ready
  input  mesh_port_pkg::port_vec_t i_output_req   [mesh_port_pkg::NUM_PORTS], // Per input
  output mesh_port_pkg::port_vec_t o_output_grant [mesh_port_pkg::NUM_PORTS], // Per output
  output logic                     o_pop          [mesh_port_pkg::NUM_PORTS]  // Per input
);

  import mesh_port_pkg::*;

  port_vec_t req_t  [NUM_PORTS]; // Transposed requests, bit p is input p
  port_vec_t gnt_t  [NUM_PORTS]; // Grants seen by each input, bit q is output q
  port_e     rr_ptr [NUM_PORTS]; // First input to look at, per output
  port_e     rr_nxt [NUM_PORTS]; // Pointer after this cycle's winner

  // First requester at or after ptr, wrapping round
  function automatic port_vec_t rr_pick(input port_vec_t req, input port_e ptr);
    port_vec_t   gnt;
    int unsigned idx;
    gnt = '0;
    for (int off = 0; off < NUM_PORTS; off++) begin
      idx = (int'(ptr) + off) % NUM_PORTS;
      if (req[idx] && (gnt == '0)) begin
        gnt[idx] = 1'b1;
      end
    end
    return gnt;
  endfunction

  // ------------------------------------------------
  // Transpose, gate with downstream enable, arbitrate
  // ------------------------------------------------
  always_comb begin
    for (int q = 0; q < NUM_PORTS; q++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        req_t[q][p] = i_output_req[p][q] & i_en[q]; // Stalled output sees no requests
      end
      o_output_grant[q] = rr_pick(req_t[q], rr_ptr[q]);
    end
  end

  // Winner moves to lowest priority
  always_comb begin
    for (int q = 0; q < NUM_PORTS; q++) begin
      rr_nxt[q] = rr_ptr[q];
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (o_output_grant[q][p]) begin
          rr_nxt[q] = port_e'((p + 1) % NUM_PORTS);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        rr_ptr[q] <= PORT_CORE;
      end
    end else begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        rr_ptr[q] <= rr_nxt[q]; // Unchanged when nothing granted
      end
    end
  end

  // ------------------------------------------------
  // Pops back to the FIFOs
  // ------------------------------------------------
  // An input requests one output only, so at most one grant hits it
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        gnt_t[p][q] = o_output_grant[q][p];
      end
      o_pop[p] = |gnt_t[p];
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_chk
    // Two grants on one head would send it out twice
    a_one_grant_per_input: assert property (@(posedge clk) disable iff (!i_rst_n)
      $onehot0(gnt_t[p]))
      else $error("input %0d granted on more than one output", p);
  end

endmodule

/* logic/mesh_switch.sv */
// ------------------------------------------------
// Crossbar from FIFO heads to output links
// Select is the one-hot grant word of each output
// ------------------------------------------------
`timescale 1ns/1ps

module mesh_switch (
  input  mesh_port_pkg::port_vec_t i_sel  [mesh_port_pkg::NUM_PORTS], // Per output
  input  mesh_pkt_pkg::packet_t    i_data [mesh_port_pkg::NUM_PORTS], // Per input
  output mesh_pkt_pkg::packet_t    o_data [mesh_port_pkg::NUM_PORTS]  // Per output
);

  import mesh_pkt_pkg::*;
  import mesh_port_pkg::*;

  // ------------------------------------------------
  // AND-OR mux per output
  // ------------------------------------------------
  // One-hot select means at most one term is nonzero,
  // no select gives an all-zero packet
  always_comb begin
    for (int q = 0; q < NUM_PORTS; q++) begin
      logic [PKT_W-1:0] acc;
      acc = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        acc = acc | (i_data[p] & {PKT_W{i_sel[q][p]}}); // Mask unselected heads
      end
      o_data[q] = packet_t'(acc);
    end
  end

endmodule

/* logic/mesh_router.sv */
// ------------------------------------------------
// Five port input buffered mesh router, XY routed
// Set X_LOC and Y_LOC to the node position in the mesh
// ------------------------------------------------
`timescale 1ns/1ps

module mesh_router #(
  parameter int unsigned X_LOC = 0, // Column of this node
  parameter int unsigned Y_LOC = 0  // Row of this node
) (
  input  logic                  clk,
  input  logic                  i_rst_n,

  // ------------------------------------------------
  // Upstream links, indexed core north east south west
  // ------------------------------------------------
  input  mesh_pkt_pkg::packet_t i_data     [mesh_port_pkg::NUM_PORTS],
  input  logic                  i_data_val [mesh_port_pkg::NUM_PORTS],
  output logic                  o_en       [mesh_port_pkg::NUM_PORTS], // FIFO not full

  // ------------------------------------------------
  // Downstream links, same port order
  // ------------------------------------------------
  output mesh_pkt_pkg::packet_t o_data     [mesh_port_pkg::NUM_PORTS],
  output logic                  o_data_val [mesh_port_pkg::NUM_PORTS],
  input  logic                  i_en       [mesh_port_pkg::NUM_PORTS]  // Neighbor can take one
);

  import mesh_pkt_pkg::*;
  import mesh_port_pkg::*;

  packet_t   l_data         [NUM_PORTS]; // FIFO heads to switch and route calc
  logic      l_data_val     [NUM_PORTS]; // Head valid per input
  port_vec_t l_output_req   [NUM_PORTS]; // Requests, indexed by input
  port_vec_t l_output_grant [NUM_PORTS]; // Grants, indexed by output
  logic      l_pop          [NUM_PORTS]; // Granted heads leave at the edge

  // Input FIFO and its route calculator, one pair per port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
    mesh_input_fifo u_fifo (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_data     (i_data[p]),
      .i_data_val (i_data_val[p]),
      .o_en       (o_en[p]),
      .i_pop      (l_pop[p]),
      .o_data     (l_data[p]),
      .o_data_val (l_data_val[p])
    );

    mesh_route_calc #(
      .X_LOC (X_LOC),
      .Y_LOC (Y_LOC)
    ) u_route (
      .i_pkt        (l_data[p]),
      .i_val        (l_data_val[p]),
      .o_output_req (l_output_req[p])
    );
  end

  // Arbitration across inputs, grants come back transposed
  mesh_switch_control u_ctrl (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_en           (i_en),
    .i_output_req   (l_output_req),
    .o_output_grant (l_output_grant),
    .o_pop          (l_pop)
  );

  mesh_switch u_switch (
    .i_sel  (l_output_grant),
    .i_data (l_data),
    .o_data (o_data)
  );

  // Any grant on an output means a packet is on the link
  for (genvar q = 0; q < NUM_PORTS; q++) begin : g_out
    assign o_data_val[q] = |l_output_grant[q];
  end

endmodule

/* sim/mesh_router_tb.sv */
// --------------------------------------------------
// Testbench for the mesh router placed at node (1,2)
// Replays the golden file phase by phase and checks every output link
// --------------------------------------------------
`timescale 1ns/1ps
`include "mesh_router_cfg.svh"

module mesh_router_tb;

  import mesh_pkt_pkg::*;
  import mesh_port_pkg::*;

  localparam int PW            = `MESH_PAYLOAD_W;
  localparam int PHASE_TIMEOUT = 400; // Cycles allowed for one phase to drain

  logic    clk;
  logic    i_rst_n;
  packet_t i_data     [NUM_PORTS];
  logic    i_data_val [NUM_PORTS];
  logic    o_en       [NUM_PORTS];
  packet_t o_data     [NUM_PORTS];
  logic    o_data_val [NUM_PORTS];
  logic    i_en       [NUM_PORTS];

  packet_t       in_q        [NUM_PORTS][$]; // Packets still to offer, per input
  logic [PW-1:0] exp_q       [NUM_PORTS][$]; // Expected payload order, per output
  int            gap         [NUM_PORTS];    // Idle cycles before next offer
  int            occ         [NUM_PORTS];    // Model of FIFO fill level
  int            stall_start [NUM_PORTS];
  int            stall_len   [NUM_PORTS];
  int            src_of      [int];          // Sending input, keyed by payload
  packet_t       sent        [int];          // Packet as offered, keyed by payload
  int            cycle;                      // Cycles since phase start
  int            seed;
  int            full_cycles;                // Input-cycles seen with o_en low

  mesh_router #(
    .X_LOC (1),
    .Y_LOC (2)
  ) mesh_router_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  // --------------------------------------------------
  // Failure reporting
  // --------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_run($sformatf("FAILED at %0d ns: %s", $time, msg));
  endtask

  function automatic logic is_stalled(input int q, input int cyc);
    return (cyc >= stall_start[q]) && (cyc < stall_start[q] + stall_len[q]);
  endfunction

  // --------------------------------------------------
  // Output monitor and FIFO fill model
  // --------------------------------------------------
  always @(posedge clk) begin
    logic [PW-1:0] got;
    logic [PW-1:0] want;
    if (i_rst_n) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        // Enable must drop exactly when the FIFO holds a full load
        assert (o_en[p] == (occ[p] < `MESH_FIFO_DEPTH))
          else report_mismatch($sformatf("o_en[%0d]=%0b with %0d packets held",
                                         p, o_en[p], occ[p]));
        if (!o_en[p]) begin
          full_cycles++;
        end
        if (i_data_val[p] && o_en[p]) begin
          occ[p]++; // Accepted at this edge
        end
      end
      for (int q = 0; q < NUM_PORTS; q++) begin
        assert (!o_data_val[q] || i_en[q])
          else report_mismatch($sformatf("output %0d valid while stalled", q));
        if (o_data_val[q]) begin
          got = o_data[q].payload;
          assert (exp_q[q].size() > 0)
            else report_mismatch($sformatf("unexpected packet %h on output %0d", got, q));
          want = exp_q[q].pop_front();
          assert (got == want)
            else report_mismatch($sformatf("output %0d gave %h, expected %h", q, got, want));
          // Destination fields ride along unchanged
          assert (o_data[q] == sent[int'(want)])
            else report_mismatch($sformatf("output %0d packet %h gave %h, expected %h",
                                           q, got, o_data[q], sent[int'(want)]));
          occ[src_of[int'(got)]]--; // Left its input FIFO at this edge
        end
      end
    end
  end

  // --------------------------------------------------
  // One phase of traffic, driven on the falling edge
  // --------------------------------------------------
  task automatic run_phase(input int phase);
    int   budget;
    logic busy;
    cycle  = 0;
    budget = PHASE_TIMEOUT;
    busy   = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      gap[p] = 0;
    end
    while (busy) begin
      @(negedge clk);
      for (int q = 0; q < NUM_PORTS; q++) begin
        i_en[q] = !is_stalled(q, cycle);
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        i_data_val[p] = 1'b0;
        if (gap[p] > 0) begin
          gap[p]--;
        end else if (in_q[p].size() > 0 && o_en[p]) begin // Offer only with room
          i_data[p]     = in_q[p].pop_front();
          i_data_val[p] = 1'b1;
          gap[p]        = int'($unsigned($random(seed)) % 3);
        end
      end
      cycle++;
      busy = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (in_q[p].size() > 0 || exp_q[p].size() > 0 || is_stalled(p, cycle) ||
            i_data_val[p]) begin
          busy = 1'b1;
        end
      end
      budget--;
      if (busy && budget == 0) begin
        stop_run($sformatf("Timed out in phase %0d waiting for the outputs to drain", phase));
      end
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      assert (occ[p] == 0)
        else report_mismatch($sformatf("input %0d still holds packets after phase %0d",
                                       p, phase));
      stall_len[p] = 0;
      i_en[p]      = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // Reset, then read and run the golden file
  // --------------------------------------------------
  initial begin
    int      fd;
    int      n;
    int      phase;
    int      port;
    int      a;
    int      b;
    int      val;
    string   tok;
    string   rest;
    packet_t pkt;
    seed        = 62897;
    full_cycles = 0;
    phase       = 0;
    i_rst_n     = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      i_data[p]      = '0;
      i_data_val[p]  = 1'b0;
      i_en[p]        = 1'b1;
      occ[p]         = 0;
      stall_start[p] = 0;
      stall_len[p]   = 0;
    end
    repeat (2) @(posedge clk); // Reset held two cycles
    @(negedge clk);
    i_rst_n = 1'b1;

    fd = $fopen("sim/mesh_router_golden.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open the golden file sim/mesh_router_golden.txt");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        void'($fgets(rest, fd)); // Rest of a comment line
      end else if (tok == "P") begin
        n = $fscanf(fd, "%d %d %d %h", port, a, b, val);
        assert (n == 4) else stop_run("Golden file has a packet line with missing fields");
        pkt.dest_x  = coord_t'(a);
        pkt.dest_y  = coord_t'(b);
        pkt.payload = PW'(val);
        in_q[port].push_back(pkt);
        src_of[val] = port;
        sent[val]   = pkt;
      end else if (tok == "S") begin
        n = $fscanf(fd, "%d %d %d", port, a, b);
        assert (n == 3) else stop_run("Golden file has a stall line with missing fields");
        stall_start[port] = a;
        stall_len[port]   = b;
      end else if (tok == "E") begin
        n = $fscanf(fd, "%d %d", port, a);
        for (int i = 0; i < a; i++) begin
          n = $fscanf(fd, "%h", val);
          exp_q[port].push_back(PW'(val));
        end
      end else if (tok == "R") begin
        phase++;
        run_phase(phase);
      end else begin
        stop_run($sformatf("Golden file has an unknown line kind %s", tok));
      end
    end
    $fclose(fd);
    repeat (4) @(negedge clk); // Idle tail catches late duplicates

    if (phase == 4 && full_cycles > 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_run("Golden file ended early or no input FIFO ever filled up");
    end
  end

endmodule

/* compile.f */
+incdir+logic
logic/mesh_pkt_pkg.sv
logic/mesh_port_pkg.sv
logic/mesh_input_fifo.sv
logic/mesh_route_calc.sv
logic/mesh_switch_control.sv
logic/mesh_switch.sv
logic/mesh_router.sv
sim/mesh_router_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the mesh router testbench with Verilator and run it
# Exit status is nonzero when the build fails or the testbench stops on $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module mesh_router_tb -f compile.f \
  && ./obj_dir/Vmesh_router_tb \
  && echo "simulation finished" \
  || { echo "build or simulation failed"; exit 1; }

/* sim/mesh_router_golden.txt */
# P in_port dest_x dest_y payload_hex | S out_port start_cycle length
# E out_port count payload_hex... | R runs the phase read so far (router at 1,2)
# Phase 1 routing from the core input in every direction
P 0 3 2 1001
P 0 0 1 1002
P 0 1 3 1003
P 0 1 0 1004
P 0 1 2 1005
P 0 2 0 1006
P 0 0 3 1007
P 0 1 1 1008
E 2 2 1001 1006
E 4 2 1002 1007
E 1 1 1003
E 3 2 1004 1008
E 0 1 1005
R
# Phase 2 north and south contend for east while east is held off
S 2 0 30
P 1 3 0 2101
P 3 2 3 2301
P 1 3 1 2102
P 3 3 3 2302
P 1 2 0 2103
P 3 2 2 2303
E 2 6 2101 2301 2102 2302 2103 2303
R
# Phase 3 west input fills up behind a stalled south output
S 3 0 40
P 4 1 0 3401
P 4 1 1 3402
P 4 1 0 3403
P 4 1 1 3404
P 4 1 0 3405
P 4 1 1 3406
E 3 6 3401 3402 3403 3404 3405 3406
R
# Phase 4 parallel traffic, each input to its own output
S 1 3 6
P 0 1 3 4001
P 1 1 0 4101
P 2 0 2 4201
P 3 1 2 4301
P 4 2 3 4401
P 0 1 3 4002
P 1 1 0 4102
P 2 0 2 4202
P 3 1 2 4302
P 4 2 3 4402
E 1 2 4001 4002
E 3 2 4101 4102
E 4 2 4201 4202
E 0 2 4301 4302
E 2 2 4401 4402
R
